/* design/rv_pkg.sv */
package rv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011
    } opcode_e;

    // The ALU decodes func3 and func7 itself unless told to add
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_reg = 2'b01,
        alu_imm = 2'b10
    } alu_op_e;

    // Values follow the func3 field of the load instructions
    typedef enum logic [2:0] {
        load_b    = 3'b000,
        load_h    = 3'b001,
        load_w    = 3'b010,
        load_bu   = 3'b100,
        load_hu   = 3'b101,
        load_none = 3'b111
    } load_type_e;

    typedef enum logic [1:0] {
        store_none = 2'b00,
        store_b    = 2'b01,
        store_h    = 2'b10,
        store_w    = 2'b11
    } store_type_e;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    ////////////////////////////////////////////////////////////////////////////
    // Stage bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [11:0] immediate;
        alu_op_e     aluop;
        logic        alu_src;
        logic [6:0]  func7;
        logic [2:0]  func3;
        logic        mem_write;
        load_type_e  mem_load_type;
        store_type_e mem_store_type;
        logic        wb_load;
        logic        wb_reg_file;
        logic [4:0]  wb_rd;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic        mem_write;
        load_type_e  mem_load_type;
        store_type_e mem_store_type;
        logic        wb_load;
        logic        wb_reg_file;
        logic [4:0]  wb_rd;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

/* design/fetch_stage.sv */
module fetch_stage (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic [31:0] if_pc,
    output logic [31:0] if_instr
);

    logic [31:0] pc;

    assign imem_addr = pc;

    // No branches, so the PC only ever steps by one word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= '0;
            if_pc    <= '0;
            if_instr <= rv_pkg::nop_instr;
        end else begin
            pc       <= pc + 32'd4;
            if_pc    <= pc;
            if_instr <= imem_data;
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic         clk,
    input  logic         rst,
    input  logic [4:0]   rs1,
    input  logic [4:0]   rs2,
    output logic [31:0]  rd1,
    output logic [31:0]  rd2,
    input  rv_pkg::wb_t  wb
);

    // x0 has no storage and reads as zero
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // A write in flight this cycle is seen by decode right away
    always_comb begin
        if (rs1 == 5'd0) begin
            rd1 = '0;
        end else if (wb.valid && wb.rd == rs1) begin
            rd1 = wb.data;
        end else begin
            rd1 = regs[rs1];
        end
        if (rs2 == 5'd0) begin
            rd2 = '0;
        end else if (wb.valid && wb.rd == rs2) begin
            rd2 = wb.data;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

/* design/decode_stage.sv */
module decode_stage (
    input  logic           clk,
    input  logic           rst,
    input  logic [31:0]    if_pc,
    input  logic [31:0]    if_instr,
    input  rv_pkg::wb_t    wb,
    output rv_pkg::id_ex_t id_out
);

    rv_pkg::opcode_e opcode;
    logic [4:0]      rd;
    logic [2:0]      func3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [6:0]      func7;
    logic [31:0]     op1;
    logic [31:0]     op2;

    assign opcode = rv_pkg::opcode_e'(if_instr[6:0]);
    assign rd     = if_instr[11:7];
    assign func3  = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign func7  = if_instr[31:25];

    reg_file reg_file_inst (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd1 (op1),
        .rd2 (op2),
        .wb  (wb)
    );

    always_comb begin
        // Start from a bundle that neither writes memory nor a register
        id_out                = '0;
        id_out.mem_load_type  = rv_pkg::load_none;
        id_out.pc             = if_pc;
        id_out.op1            = op1;
        id_out.op2            = op2;
        id_out.func7          = func7;
        id_out.func3          = func3;
        id_out.wb_rd          = rd;
        id_out.immediate      = (opcode == rv_pkg::op_store) ? {func7, rd} : if_instr[31:20];

        case (opcode)
            rv_pkg::op_reg: begin
                id_out.aluop       = rv_pkg::alu_reg;
                id_out.wb_reg_file = 1'b1;
            end
            rv_pkg::op_imm: begin
                id_out.aluop       = rv_pkg::alu_imm;
                id_out.alu_src     = 1'b1;
                id_out.wb_reg_file = 1'b1;
            end
            rv_pkg::op_load: begin
                id_out.alu_src       = 1'b1;
                id_out.mem_load_type = rv_pkg::load_type_e'(func3);
                id_out.wb_load       = 1'b1;
                id_out.wb_reg_file   = 1'b1;
            end
            rv_pkg::op_store: begin
                id_out.alu_src   = 1'b1;
                id_out.mem_write = 1'b1;
                case (func3)
                    3'b000:  id_out.mem_store_type = rv_pkg::store_b;
                    3'b001:  id_out.mem_store_type = rv_pkg::store_h;
                    default: id_out.mem_store_type = rv_pkg::store_w;
                endcase
            end
            default: begin
                id_out.wb_rd = 5'd0;
            end
        endcase
    end

endmodule

/* design/id_ex_pipeline.sv */
module id_ex_pipeline (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::id_ex_t id_in,
    output rv_pkg::id_ex_t ex_out
);

    // Reset leaves a no-op in the execute stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_out               <= '0;
            ex_out.mem_load_type <= rv_pkg::load_none;
        end else begin
            ex_out <= id_in;
        end
    end

endmodule

/* design/execute_stage.sv */
module execute_stage (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::id_ex_t  ex_in,
    output rv_pkg::ex_mem_t mem_out
);

    logic [31:0] imm_ext;
    logic [31:0] operand_b;
    logic [4:0]  shamt;
    logic [31:0] result;

    assign imm_ext   = {{20{ex_in.immediate[11]}}, ex_in.immediate};
    assign operand_b = ex_in.alu_src ? imm_ext : ex_in.op2;
    assign shamt     = operand_b[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (ex_in.aluop == rv_pkg::alu_add) begin
            result = ex_in.op1 + operand_b;
        end else begin
            case (ex_in.func3)
                3'b000: begin
                    // ADDI never subtracts, whatever its upper immediate bits are
                    if (ex_in.aluop == rv_pkg::alu_reg && ex_in.func7[5]) begin
                        result = ex_in.op1 - operand_b;
                    end else begin
                        result = ex_in.op1 + operand_b;
                    end
                end
                3'b001: result = ex_in.op1 << shamt;
                3'b010: result = {31'd0, $signed(ex_in.op1) < $signed(operand_b)};
                3'b011: result = {31'd0, ex_in.op1 < operand_b};
                3'b100: result = ex_in.op1 ^ operand_b;
                3'b101: begin
                    if (ex_in.func7[5]) begin
                        result = $unsigned($signed(ex_in.op1) >>> shamt);
                    end else begin
                        result = ex_in.op1 >> shamt;
                    end
                end
                3'b110: result = ex_in.op1 | operand_b;
                default: result = ex_in.op1 & operand_b;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_out               <= '0;
            mem_out.mem_load_type <= rv_pkg::load_none;
        end else begin
            mem_out.alu_result     <= result;
            mem_out.store_data     <= ex_in.op2;
            mem_out.mem_write      <= ex_in.mem_write;
            mem_out.mem_load_type  <= ex_in.mem_load_type;
            mem_out.mem_store_type <= ex_in.mem_store_type;
            mem_out.wb_load        <= ex_in.wb_load;
            mem_out.wb_reg_file    <= ex_in.wb_reg_file;
            mem_out.wb_rd          <= ex_in.wb_rd;
        end
    end

endmodule

/* design/memory_stage.sv */
module memory_stage #(
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::ex_mem_t mem_in,
    output rv_pkg::wb_t     wb
);

    localparam int addr_bits = $clog2(dmem_words);

    logic [31:0]          dmem [dmem_words];
    logic [addr_bits-1:0] word_idx;
    logic [1:0]           byte_off;
    logic [3:0]           byte_en;
    logic [31:0]          wdata;
    logic [31:0]          rdata;
    logic [7:0]           rbyte;
    logic [15:0]          rhalf;
    logic [31:0]          load_data;

    assign word_idx = mem_in.alu_result[2 +: addr_bits];
    assign byte_off = mem_in.alu_result[1:0];

    // Replicate the store data so every lane sees its bytes
    always_comb begin
        case (mem_in.mem_store_type)
            rv_pkg::store_b: begin
                byte_en = 4'b0001 << byte_off;
                wdata   = {4{mem_in.store_data[7:0]}};
            end
            rv_pkg::store_h: begin
                byte_en = 4'b0011 << {byte_off[1], 1'b0};
                wdata   = {2{mem_in.store_data[15:0]}};
            end
            rv_pkg::store_w: begin
                byte_en = 4'b1111;
                wdata   = mem_in.store_data;
            end
            default: begin
                byte_en = 4'b0000;
                wdata   = mem_in.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_in.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    dmem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = dmem[word_idx];
    assign rbyte = rdata[8*byte_off +: 8];
    assign rhalf = rdata[16*byte_off[1] +: 16];

    always_comb begin
        case (mem_in.mem_load_type)
            rv_pkg::load_b:  load_data = {{24{rbyte[7]}}, rbyte};
            rv_pkg::load_bu: load_data = {24'd0, rbyte};
            rv_pkg::load_h:  load_data = {{16{rhalf[15]}}, rhalf};
            rv_pkg::load_hu: load_data = {16'd0, rhalf};
            default:         load_data = rdata;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.valid <= mem_in.wb_reg_file && (mem_in.wb_rd != 5'd0);
            wb.rd    <= mem_in.wb_rd;
            wb.data  <= mem_in.wb_load ? load_data : mem_in.alu_result;
        end
    end

endmodule

/* design/rv_core_top.sv */
module rv_core_top #(
    parameter int dmem_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output rv_pkg::wb_t wb
);

    logic [31:0]     if_pc;
    logic [31:0]     if_instr;
    rv_pkg::id_ex_t  id_bundle;
    rv_pkg::id_ex_t  ex_bundle;
    rv_pkg::ex_mem_t mem_bundle;

    fetch_stage fetch_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_pc     (if_pc),
        .if_instr  (if_instr)
    );

    // The writeback bus feeds the register file write port in decode
    decode_stage decode_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .wb       (wb),
        .id_out   (id_bundle)
    );

    id_ex_pipeline id_ex_pipeline_inst (
        .clk    (clk),
        .rst    (rst),
        .id_in  (id_bundle),
        .ex_out (ex_bundle)
    );

    execute_stage execute_stage_inst (
        .clk     (clk),
        .rst     (rst),
        .ex_in   (ex_bundle),
        .mem_out (mem_bundle)
    );

    memory_stage #(
        .dmem_words (dmem_words)
    ) memory_stage_inst (
        .clk    (clk),
        .rst    (rst),
        .mem_in (mem_bundle),
        .wb     (wb)
    );

endmodule

/* dv/rv_core_tb.sv */
module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int reset_cycles = 16;
    localparam int drain_cycles = 8;
    localparam logic [31:0] nop_word = 32'h0000_0013;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_reg = 7'b0110011;

    typedef enum int {
        do_add, do_sub, do_sll, do_slt, do_sltu, do_xor, do_srl, do_sra, do_or, do_and
    } alu_kind_e;

    typedef struct packed {
        logic [31:0] idx;
        logic [4:0]  rd;
        logic [31:0] data;
    } exp_write_t;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    rv_pkg::wb_t wb;

    logic [31:0] prog [0:511];
    int          prog_len;
    logic [31:0] reg_model [0:31];
    logic [7:0]  mem_model [0:1023];
    exp_write_t  exp_q [$];
    integer      seed;
    int          cycle_limit;
    int          total_cycles;

    rv_core_top #(
        .dmem_words (256)
    ) rv_core_top_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        total_cycles++;
        assert (total_cycles < cycle_limit) else begin
            fail_run("Timeout because the run went past its cycle budget");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assembler and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [2:0] kind_f3(input alu_kind_e kind);
        case (kind)
            do_add, do_sub: return 3'b000;
            do_sll:         return 3'b001;
            do_slt:         return 3'b010;
            do_sltu:        return 3'b011;
            do_xor:         return 3'b100;
            do_srl, do_sra: return 3'b101;
            do_or:          return 3'b110;
            default:        return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input alu_kind_e kind, input logic [31:0] a,
                                              input logic [31:0] b);
        case (kind)
            do_add:  return a + b;
            do_sub:  return a - b;
            do_sll:  return a << b[4:0];
            do_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            do_sltu: return (a < b) ? 32'd1 : 32'd0;
            do_xor:  return a ^ b;
            do_srl:  return a >> b[4:0];
            do_sra:  return $signed(a) >>> b[4:0];
            do_or:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [11:0] rand12();
        return 12'($random(seed));
    endfunction

    function automatic logic [4:0] pick_reg(input int n);
        return 5'(1 + ({$random(seed)} % n));
    endfunction

    task automatic start_program();
        int i;
        prog_len = 0;
        for (i = 0; i < 32; i++) begin
            reg_model[i] = '0;
        end
        exp_q.delete();
    endtask

    // Two nops follow every instruction so no result is read too early
    task automatic place(input logic [31:0] instr);
        prog[prog_len] = instr;
        prog[prog_len + 1] = nop_word;
        prog[prog_len + 2] = nop_word;
        prog_len += 3;
    endtask

    task automatic expect_write(input logic [4:0] rd, input logic [31:0] data);
        if (rd != 5'd0) begin
            exp_q.push_back('{idx: 32'(prog_len), rd: rd, data: data});
            reg_model[rd] = data;
        end
    endtask

    task automatic emit_imm(input alu_kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        expect_write(rd, alu_model(kind, reg_model[rs1], sext12(imm)));
        place(enc_i(opc_imm, kind_f3(kind), rd, rs1, imm));
    endtask

    task automatic emit_reg(input alu_kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (kind == do_sub || kind == do_sra) ? 7'b0100000 : 7'b0000000;
        expect_write(rd, alu_model(kind, reg_model[rs1], reg_model[rs2]));
        place(enc_r(f7, kind_f3(kind), rd, rs1, rs2));
    endtask

    task automatic emit_store(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [11:0] imm);
        logic [31:0] addr;
        int          i;
        addr = reg_model[rs1] + sext12(imm);
        for (i = 0; i < (1 << f3[1:0]); i++) begin
            mem_model[10'(addr + 32'(i))] = reg_model[rs2][8*i +: 8];
        end
        place(enc_s(f3, rs1, rs2, imm));
    endtask

    // Little-endian bytes, sign extended unless func3 bit 2 asks for zero extension
    task automatic emit_load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        logic [31:0] addr;
        logic [31:0] raw;
        logic [31:0] value;
        int          i;
        addr = reg_model[rs1] + sext12(imm);
        raw = '0;
        for (i = 0; i < (1 << f3[1:0]); i++) begin
            raw[8*i +: 8] = mem_model[10'(addr + 32'(i))];
        end
        if (f3[2] || f3[1:0] == 2'b10) begin
            value = raw;
        end else if (f3[1:0] == 2'b00) begin
            value = {{24{raw[7]}}, raw[7:0]};
        end else begin
            value = {{16{raw[15]}}, raw[15:0]};
        end
        expect_write(rd, value);
        place(enc_i(opc_load, f3, rd, rs1, imm));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Running a program
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_imem();
        if (imem_addr < 32'(4 * prog_len)) begin
            imem_data = prog[imem_addr[10:2]];
        end else begin
            imem_data = nop_word;
        end
    endtask

    // Cycle k shows address 4k, so instruction k writes back in cycle k+4
    task automatic observe_wb(input int cycle);
        exp_write_t e;
        if (cycle < 4) begin
            check_value("wb.valid", 32'(wb.valid), 32'd0);
        end
        if (wb.valid) begin
            assert (exp_q.size() != 0) else begin
                fail_run($sformatf("Unexpected register write to x%0d in cycle %0d",
                                   wb.rd, cycle));
            end
            e = exp_q.pop_front();
            assert (32'(cycle) == e.idx + 32'd4) else begin
                fail_run($sformatf("Write to x%0d came in cycle %0d but was due in cycle %0d",
                                   e.rd, cycle, e.idx + 32'd4));
            end
            check_value("wb.rd", 32'(wb.rd), 32'(e.rd));
            check_value("wb.data", wb.data, e.data);
        end
    endtask

    task automatic run_program(input string name);
        int          k;
        int          cycle;
        logic [31:0] end_addr;
        end_addr = 32'(4 * (prog_len + drain_cycles));
        cycle_limit += 2 * (reset_cycles + prog_len + drain_cycles);
        @(negedge clk);
        rst = 1'b1;
        drive_imem();
        for (k = 0; k < reset_cycles; k++) begin
            @(negedge clk);
            check_value("imem_addr", imem_addr, 32'd0);
            check_value("wb.valid", 32'(wb.valid), 32'd0);
            drive_imem();
        end
        rst = 1'b0;
        cycle = 0;
        while (imem_addr != end_addr) begin
            check_value("imem_addr", imem_addr, 32'(4 * cycle));
            observe_wb(cycle);
            drive_imem();
            @(negedge clk);
            cycle++;
        end
        assert (exp_q.size() == 0) else begin
            fail_run($sformatf("%0d expected register writes never appeared", exp_q.size()));
        end
        $display("Test %s finished", name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_fetch();
        start_program();
        place(nop_word);
        place(nop_word);
        run_program("reset and fetch");
    endtask

    task automatic test_imm_alu();
        int i;
        start_program();
        for (i = 1; i <= 6; i++) begin
            emit_imm(do_add, 5'(i), 5'd0, rand12());
        end
        emit_imm(do_add, 5'd7, 5'd0, 12'h800 | rand12());
        emit_imm(do_add, 5'd8, 5'd1, rand12());
        emit_imm(do_slt, 5'd9, pick_reg(8), rand12());
        emit_imm(do_sltu, 5'd10, pick_reg(8), rand12());
        emit_imm(do_xor, 5'd11, pick_reg(8), rand12());
        emit_imm(do_or, 5'd12, pick_reg(8), rand12());
        emit_imm(do_and, 5'd13, pick_reg(8), rand12());
        emit_imm(do_sll, 5'd14, 5'd7, rand12() & 12'h01f);
        emit_imm(do_srl, 5'd15, 5'd7, rand12() & 12'h01f);
        emit_imm(do_sra, 5'd16, 5'd7, 12'h400 | (rand12() & 12'h01f));
        run_program("immediate ALU");
    endtask

    task automatic test_reg_alu();
        int k;
        start_program();
        for (k = 1; k <= 3; k++) begin
            emit_imm(do_add, 5'(k), 5'd0, rand12());
        end
        emit_imm(do_add, 5'd4, 5'd0, 12'h800 | rand12());
        for (k = 0; k < 10; k++) begin
            emit_reg(alu_kind_e'(k), 5'(10 + k), pick_reg(4), pick_reg(4));
        end
        run_program("register ALU");
    endtask

    task automatic test_store_load();
        int off;
        int n;
        start_program();
        emit_imm(do_add, 5'd1, 5'd0, 12'h040);
        emit_imm(do_add, 5'd2, 5'd0, rand12());
        emit_imm(do_add, 5'd3, 5'd0, rand12());
        emit_imm(do_sll, 5'd4, 5'd3, 12'd16);
        emit_reg(do_xor, 5'd5, 5'd4, 5'd2);
        emit_imm(do_sll, 5'd6, 5'd5, 12'd9);
        emit_reg(do_xor, 5'd6, 5'd6, 5'd3);
        emit_store(3'b010, 5'd1, 5'd5, 12'd0);
        emit_store(3'b010, 5'd1, 5'd6, 12'd4);
        emit_store(3'b010, 5'd1, 5'd5, 12'd8);
        emit_store(3'b010, 5'd1, 5'd6, 12'hff8);
        emit_store(3'b001, 5'd1, 5'd2, 12'd2);
        emit_store(3'b001, 5'd1, 5'd3, 12'd8);
        emit_store(3'b000, 5'd1, 5'd3, 12'd5);
        emit_store(3'b000, 5'd1, 5'd2, 12'd11);
        n = 0;
        for (off = 0; off < 12; off++) begin
            emit_load(3'b000, 5'(8 + (n++ % 24)), 5'd1, 12'(off));
            emit_load(3'b100, 5'(8 + (n++ % 24)), 5'd1, 12'(off));
            if (off % 2 == 0) begin
                emit_load(3'b001, 5'(8 + (n++ % 24)), 5'd1, 12'(off));
                emit_load(3'b101, 5'(8 + (n++ % 24)), 5'd1, 12'(off));
            end
            if (off % 4 == 0) begin
                emit_load(3'b010, 5'(8 + (n++ % 24)), 5'd1, 12'(off));
            end
        end
        emit_load(3'b010, 5'd7, 5'd1, 12'hff8);
        run_program("stores and loads");
    endtask

    task automatic test_x0_latency();
        start_program();
        emit_imm(do_add, 5'd5, 5'd0, rand12());
        emit_imm(do_add, 5'd0, 5'd5, rand12());
        emit_reg(do_add, 5'd0, 5'd5, 5'd5);
        emit_imm(do_sll, 5'd0, 5'd5, 12'd3);
        emit_load(3'b010, 5'd0, 5'd0, 12'h040);
        emit_imm(do_xor, 5'd6, 5'd5, rand12());
        run_program("x0 writes and latency");
    endtask

    initial begin
        seed = 32'h8b645bbd;
        cycle_limit = 0;
        total_cycles = 0;
        rst = 1'b1;
        imem_data = nop_word;
        prog_len = 0;
        test_reset_fetch();
        test_imm_alu();
        test_reg_alu();
        test_store_load();
        test_x0_latency();
        $display("all tests passed");
        $finish;
    end

endmodule

/* list.f */
design/rv_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/id_ex_pipeline.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core_top.sv
dv/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rv_core_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
